//--- vec_core.f
hw/vec_pkg.sv
hw/vec_ctrl.sv
hw/vec_regfile.sv
hw/vec_alu.sv
hw/vec_mem_port.sv
hw/vec_core.sv
bench/vec_core_chk.sv
bench/vec_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= vec_core_tb
FILELIST  ?= vec_core.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/vec_core_tests.txt
// records are a kind word and two hex words, one program step per line
// kind 1 preload addr data, kind 2 insn word rs1, kind 3 expected store addr data
1 100 00ff80f0123456ff  1 108 000180f100ff0f01  1 110 1111ffff00018000
2 02007087 100  2 02007107 108
2 00007057 0
2 021101d7 0  2 020071a7 300  3 300 000000e112336500
2 0a110257 0  2 02007227 308  3 308 00fe00ff123547fe
2 261102d7 0  2 020072a7 310  3 310 000180f000340601
2 2a110357 0  2 02007327 318  3 318 00ff80f112ff5fff
2 2e1103d7 0  2 020073a7 320  3 320 00fe000112cb59fe
2 01807057 0
2 02110457 0  2 02007427 328  3 328 010101e113336600
2 0a1104d7 0  2 020074a7 330  3 330 00fdffff113547fe
2 26110557 0  2 02007527 338  3 338 000180f000340601
2 2a1105d7 0  2 020075a7 340  3 340 00ff80f112ff5fff
2 2e110657 0  2 02007627 348  3 348 00fe000112cb59fe
2 00807057 0
2 021eb6d7 0  2 020076a7 350  3 350 00fc80ed123156fc
2 020070a7 358  3 358 00ff80f0123456ff
2 02007707 110  2 02e087d7 0  2 020077a7 360  3 360 121080ef1235d6ff

//--- bench/vec_core_tb.sv
module vec_core_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import vec_pkg::*;

    // room for the test records, three words each
    localparam int TEST_WORDS = 384;

    logic   clk;
    logic   rst_n;
    insn_t  insn;
    waddr_t rs1_value;
    logic   insn_valid;
    vreg_t  wb_dat_i;
    logic   wb_ack;
    logic   insn_ready;
    logic   wb_cyc;
    logic   wb_stb;
    logic   wb_we;
    waddr_t wb_adr;
    vreg_t  wb_dat_o;

    logic [63:0] tests [TEST_WORDS];
    // program, then the bus traffic it must produce
    insn_t  insn_q [$];
    waddr_t rs1_q [$];
    waddr_t exp_addr_q [$];
    vreg_t  exp_data_q [$];
    // sparse word memory behind the slave
    vreg_t  mem [waddr_t];
    integer seed = 32'h231d391b;
    int     wait_left = 0;
    logic   in_req = 1'b0;
    int     num_records = 0;
    int     timeout_cycles = 0;

    vec_core #(.NUM_VEC(NUM_VEC)) vec_core_inst (.*);

    bind vec_core vec_core_chk vec_core_chk_inst (.*);

    always #5 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_vreg(input string name, input vreg_t got, input vreg_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input waddr_t got, input waddr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    // untouched words read back a value built from the whole address
    function automatic vreg_t fill_word(input waddr_t addr);
        return {addr ^ 32'h5a5a_5a5a, ~addr};
    endfunction

    // drive on the falling edge, hold until the core takes it
    task automatic issue(input insn_t word, input waddr_t addr);
        @(negedge clk);
        insn       <= word;
        rs1_value  <= addr;
        insn_valid <= 1'b1;
        do begin
            @(posedge clk);
        end while (!insn_ready);
    endtask

    // answer the open request, stores are checked in program order
    task automatic serve_request();
        if (wb_we) begin
            if (exp_data_q.size() == 0) begin
                abort_run($sformatf("store to %h at %0t ns was not expected", wb_adr, $time));
            end
            check_addr("wb_adr", wb_adr, exp_addr_q.pop_front());
            check_vreg("wb_dat_o", wb_dat_o, exp_data_q.pop_front());
            mem[wb_adr] = wb_dat_o;
        end else begin
            wb_dat_i <= mem.exists(wb_adr) ? mem[wb_adr] : fill_word(wb_adr);
        end
    endtask

    // wishbone slave, 0 to 3 wait cycles per request
    always @(negedge clk) begin
        if (wb_ack) begin
            wb_ack <= 1'b0;
            in_req = 1'b0;
        end else if (rst_n && wb_cyc && wb_stb) begin
            if (!in_req) begin
                in_req = 1'b1;
                wait_left = $unsigned($random(seed)) % 4;
            end
            if (wait_left == 0) begin
                serve_request();
                wb_ack <= 1'b1;
            end else begin
                wait_left--;
            end
        end
    end

    initial begin : main
        int i;
        clk        = 1'b0;
        rst_n      = 1'b0;
        insn       = '0;
        rs1_value  = '0;
        insn_valid = 1'b0;
        wb_dat_i   = '0;
        wb_ack     = 1'b0;
        for (i = 0; i < TEST_WORDS; i++) begin
            tests[i] = '0;
        end
        $readmemh("bench/vec_core_tests.txt", tests);
        // split records by kind until the first empty slot
        i = 0;
        while (i + 2 < TEST_WORDS && tests[i] >= 64'd1 && tests[i] <= 64'd3) begin
            case (tests[i])
                64'd1: mem[tests[i+1][31:0]] = tests[i+2];
                64'd2: begin
                    insn_q.push_back(tests[i+1][31:0]);
                    rs1_q.push_back(tests[i+2][31:0]);
                end
                default: begin
                    exp_addr_q.push_back(tests[i+1][31:0]);
                    exp_data_q.push_back(tests[i+2]);
                end
            endcase
            num_records++;
            i += 3;
        end
        if (insn_q.size() == 0) begin
            abort_run("the test file holds no instructions");
        end
        timeout_cycles = num_records * 20;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n <= 1'b1;
        for (int k = 0; k < insn_q.size(); k++) begin
            issue(insn_q[k], rs1_q[k]);
        end
        @(negedge clk);
        insn_valid <= 1'b0;
        // drain outstanding stores
        while (exp_data_q.size() != 0 || wb_cyc) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
        // let the assertions of the last edge settle
        @(negedge clk);
        $display("Test completed successfully");
        $finish;
    end

    // a failed bus or intake assertion ends the run at once
    initial begin : assert_watch
        wait (vec_core_inst.vec_core_chk_inst.fail_count != 0);
        abort_run("an assertion on the bus or intake signals failed");
    end

    // budget scales with the number of records
    initial begin : watchdog
        wait (timeout_cycles != 0);
        repeat (timeout_cycles) @(posedge clk);
        abort_run($sformatf("timeout, the run did not finish within %0d cycles", timeout_cycles));
    end

endmodule

//--- bench/vec_core_chk.sv
module vec_core_chk (
    input logic             clk,
    input logic             rst_n,
    input logic             insn_ready,
    input logic             wb_cyc,
    input logic             wb_stb,
    input logic             wb_we,
    input logic             wb_ack,
    input vec_pkg::waddr_t  wb_adr,
    input vec_pkg::vreg_t   wb_dat_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // bumped on every failing assertion
    int unsigned fail_count = 0;

    // cycle and strobe both close in the cycle after ack
    close_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |=> (!wb_cyc && !wb_stb))
        else begin
            $error("wb_cyc or wb_stb still high in the cycle after ack");
            fail_count++;
        end

    // request held steady through wait states
    req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_stb && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_o)))
        else begin
            $error("wishbone request changed before ack");
            fail_count++;
        end

    // first cycle out of reset is quiet
    quiet_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> (!insn_ready && !wb_cyc))
        else begin
            $error("insn_ready or wb_cyc active right after reset");
            fail_count++;
        end

endmodule

//--- hw/vec_core.sv
module vec_core #(
    parameter int NUM_VEC = vec_pkg::NUM_VEC
) (
    input  logic             clk,
    input  logic             rst_n,
    input  vec_pkg::insn_t   insn,
    input  vec_pkg::waddr_t  rs1_value,
    input  logic             insn_valid,
    input  vec_pkg::vreg_t   wb_dat_i,
    input  logic             wb_ack,
    output logic             insn_ready,
    output logic             wb_cyc,
    output logic             wb_stb,
    output logic             wb_we,
    output vec_pkg::waddr_t  wb_adr,
    output vec_pkg::vreg_t   wb_dat_o
);
    import vec_pkg::*;

    // regfile read side
    vidx_t   rd_idx_a;
    vidx_t   rd_idx_b;
    vreg_t   rd_data_a;
    vreg_t   rd_data_b;
    // alu issue and result
    logic    alu_valid;
    alu_op_t alu_op;
    logic    alu_use_imm;
    logic [4:0] alu_imm;
    sew_t    alu_sew;
    vidx_t   alu_vd;
    vreg_t   alu_src_a;
    vreg_t   alu_src_b;
    logic    res_valid;
    vidx_t   res_vd;
    vreg_t   res_data;
    // memory port issue and load return
    logic    mem_start;
    logic    mem_we;
    waddr_t  mem_addr;
    vreg_t   mem_wdata;
    vidx_t   mem_vd;
    logic    mem_busy;
    logic    ld_valid;
    vidx_t   ld_vd;
    vreg_t   ld_data;
    logic    ld_taken;
    // shared write port
    logic    wr_en;
    vidx_t   wr_idx;
    vreg_t   wr_data;

    // alu result wins the port, load waits a cycle
    assign wr_en    = res_valid || ld_valid;
    assign wr_idx   = res_valid ? res_vd : ld_vd;
    assign wr_data  = res_valid ? res_data : ld_data;
    assign ld_taken = ld_valid && !res_valid;

    // port names line up one to one with the wires above
    vec_ctrl #(.NUM_VEC(NUM_VEC)) vec_ctrl_inst (.*);

    vec_regfile #(.NUM_VEC(NUM_VEC)) vec_regfile_inst (.*);

    vec_alu vec_alu_inst (.*);

    vec_mem_port vec_mem_port_inst (.*);

endmodule

//--- hw/vec_mem_port.sv
module vec_mem_port (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             mem_start,
    input  logic             mem_we,
    input  vec_pkg::waddr_t  mem_addr,
    input  vec_pkg::vreg_t   mem_wdata,
    input  vec_pkg::vidx_t   mem_vd,
    input  logic             ld_taken,
    input  vec_pkg::vreg_t   wb_dat_i,
    input  logic             wb_ack,
    output logic             mem_busy,
    output logic             ld_valid,
    output vec_pkg::vidx_t   ld_vd,
    output vec_pkg::vreg_t   ld_data,
    output logic             wb_cyc,
    output logic             wb_stb,
    output logic             wb_we,
    output vec_pkg::waddr_t  wb_adr,
    output vec_pkg::vreg_t   wb_dat_o
);
    import vec_pkg::*;

    // idle, bus cycle open, load data waiting for the write port
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUS,
        ST_LDRES
    } state_t;

    state_t state;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE:  if (mem_start) state <= ST_BUS;
                // store is done at ack, load still has to write back
                ST_BUS:   if (wb_ack) state <= wb_we ? ST_IDLE : ST_LDRES;
                ST_LDRES: if (ld_taken) state <= ST_IDLE;
                default:  state <= ST_IDLE;
            endcase
        end
    end

    // request latched once, held steady through wait states
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && mem_start) begin
            wb_adr   <= mem_addr;
            wb_we    <= mem_we;
            wb_dat_o <= mem_wdata;
            ld_vd    <= mem_vd;
        end
        if (state == ST_BUS && wb_ack) begin
            ld_data <= wb_dat_i;
        end
    end

    // cyc and stb together, single-beat classic cycle
    assign wb_cyc   = (state == ST_BUS);
    assign wb_stb   = (state == ST_BUS);
    assign mem_busy = (state == ST_BUS);
    assign ld_valid = (state == ST_LDRES);

endmodule

//--- hw/vec_alu.sv
module vec_alu (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              alu_valid,
    input  vec_pkg::alu_op_t  alu_op,
    input  logic              alu_use_imm,
    input  logic [4:0]        alu_imm,
    input  vec_pkg::sew_t     alu_sew,
    input  vec_pkg::vidx_t    alu_vd,
    input  vec_pkg::vreg_t    alu_src_a,
    input  vec_pkg::vreg_t    alu_src_b,
    output logic              res_valid,
    output vec_pkg::vidx_t    res_vd,
    output vec_pkg::vreg_t    res_data
);
    import vec_pkg::*;

    vreg_t      imm_vec;
    vreg_t      opnd_b;
    vreg_t      b_eff;
    vreg_t      sum;
    vreg_t      result;
    logic       do_sub;
    // byte offset bits inside one lane
    logic [2:0] lane_mask;

    // simm5 sign-extended to sew, copied into every lane
    always_comb begin
        case (alu_sew)
            2'd0:    imm_vec = {(VLEN/8){{3{alu_imm[4]}}, alu_imm}};
            2'd1:    imm_vec = {(VLEN/16){{11{alu_imm[4]}}, alu_imm}};
            2'd2:    imm_vec = {(VLEN/32){{27{alu_imm[4]}}, alu_imm}};
            default: imm_vec = {{(VLEN-5){alu_imm[4]}}, alu_imm};
        endcase
        case (alu_sew)
            2'd0:    lane_mask = 3'b000;
            2'd1:    lane_mask = 3'b001;
            2'd2:    lane_mask = 3'b011;
            default: lane_mask = 3'b111;
        endcase
    end

    assign opnd_b = alu_use_imm ? imm_vec : alu_src_b;
    assign do_sub = (alu_op == ALU_SUB);
    // subtract as a + ~b + 1, the +1 enters at each lane start
    assign b_eff  = do_sub ? ~opnd_b : opnd_b;

    // byte-sliced adder, carry chain cut at lane boundaries
    always_comb begin : lane_add
        logic [8:0] part;
        logic       carry;
        carry = 1'b0;
        part  = '0;
        for (int i = 0; i < VLEN / 8; i++) begin
            if ((3'(i) & lane_mask) == 3'd0) begin
                carry = do_sub;
            end
            part = {1'b0, alu_src_a[i*8 +: 8]} + {1'b0, b_eff[i*8 +: 8]} + 9'(carry);
            sum[i*8 +: 8] = part[7:0];
            carry = part[8];
        end
    end

    always_comb begin
        case (alu_op)
            ALU_AND: result = alu_src_a & opnd_b;
            ALU_OR:  result = alu_src_a | opnd_b;
            ALU_XOR: result = alu_src_a ^ opnd_b;
            // add and sub share the adder
            default: result = sum;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= alu_valid;
        end
    end

    // result payload, only valid qualifies it
    always_ff @(posedge clk) begin
        if (alu_valid) begin
            res_vd   <= alu_vd;
            res_data <= result;
        end
    end

endmodule

//--- hw/vec_regfile.sv
module vec_regfile #(
    parameter int NUM_VEC = vec_pkg::NUM_VEC
) (
    input  logic            clk,
    input  vec_pkg::vidx_t  rd_idx_a,
    input  vec_pkg::vidx_t  rd_idx_b,
    input  logic            wr_en,
    input  vec_pkg::vidx_t  wr_idx,
    input  vec_pkg::vreg_t  wr_data,
    output vec_pkg::vreg_t  rd_data_a,
    output vec_pkg::vreg_t  rd_data_b
);
    import vec_pkg::*;

    // plain flop array
    vreg_t regs [NUM_VEC];

    // single write port, alu or load picked upstream
    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // async reads
    // a write in flight is not forwarded, the scoreboard covers that
    assign rd_data_a = regs[rd_idx_a];
    assign rd_data_b = regs[rd_idx_b];

endmodule

//--- hw/vec_ctrl.sv
module vec_ctrl #(
    parameter int NUM_VEC = vec_pkg::NUM_VEC
) (
    input  logic              clk,
    input  logic              rst_n,
    input  vec_pkg::insn_t    insn,
    input  vec_pkg::waddr_t   rs1_value,
    input  logic              insn_valid,
    input  logic              mem_busy,
    input  logic              res_valid,
    input  vec_pkg::vidx_t    res_vd,
    input  logic              ld_valid,
    input  vec_pkg::vidx_t    ld_vd,
    input  vec_pkg::vreg_t    rd_data_a,
    input  vec_pkg::vreg_t    rd_data_b,
    output logic              insn_ready,
    output vec_pkg::vidx_t    rd_idx_a,
    output vec_pkg::vidx_t    rd_idx_b,
    output logic              alu_valid,
    output vec_pkg::alu_op_t  alu_op,
    output logic              alu_use_imm,
    output logic [4:0]        alu_imm,
    output vec_pkg::sew_t     alu_sew,
    output vec_pkg::vidx_t    alu_vd,
    output vec_pkg::vreg_t    alu_src_a,
    output vec_pkg::vreg_t    alu_src_b,
    output logic              mem_start,
    output logic              mem_we,
    output vec_pkg::waddr_t   mem_addr,
    output vec_pkg::vreg_t    mem_wdata,
    output vec_pkg::vidx_t    mem_vd
);
    import vec_pkg::*;

    // instruction fields, decoded straight off the intake
    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic [5:0]         funct6;
    vidx_t              vd;
    vidx_t              vs1;
    vidx_t              vs2;
    logic               is_ivv;
    logic               is_ivi;
    logic               is_cfg;
    logic               is_load;
    logic               is_store;
    logic               is_mem;
    logic               is_arith;
    logic               op_ok;
    alu_op_t            op_dec;
    // one pending bit per register
    logic [NUM_VEC-1:0] pend;
    logic               hazard;
    logic               mem_block;
    logic               alu_block;
    logic               run;
    logic               accept;
    sew_t               sew_q;

    assign opcode = insn[6:0];
    assign vd     = insn[11:7];
    assign funct3 = insn[14:12];
    assign vs1    = insn[19:15];
    assign vs2    = insn[24:20];
    assign funct6 = insn[31:26];

    assign is_ivv   = (opcode == OPC_OPV) && (funct3 == F3_IVV);
    assign is_ivi   = (opcode == OPC_OPV) && (funct3 == F3_IVI);
    // vsetvli only, bit 31 clear
    assign is_cfg   = (opcode == OPC_OPV) && (funct3 == F3_CFG) && !insn[31];
    assign is_load  = (opcode == OPC_LOAD);
    assign is_store = (opcode == OPC_STORE);
    assign is_mem   = is_load || is_store;
    // unknown funct6 is consumed without effect
    assign is_arith = (is_ivv || is_ivi) && op_ok;

    always_comb begin
        op_dec = ALU_ADD;
        op_ok  = 1'b1;
        case (funct6)
            F6_ADD:  op_dec = ALU_ADD;
            F6_SUB:  op_dec = ALU_SUB;
            F6_AND:  op_dec = ALU_AND;
            F6_OR:   op_dec = ALU_OR;
            F6_XOR:  op_dec = ALU_XOR;
            default: op_ok  = 1'b0;
        endcase
    end

    // raw on vs1/vs2/vs3, waw on vd
    // a bit cleared this cycle still stalls, the write lands on the edge
    assign hazard = (is_arith && is_ivv && pend[vs1])
                 || (is_arith && pend[vs2])
                 || ((is_arith || is_load || is_store) && pend[vd]);

    // one bus transfer at a time, and none while a load result waits
    assign mem_block = is_mem && (mem_busy || ld_valid);
    // load lost the write port, keep the alu quiet so it gets the next edge
    assign alu_block = is_arith && ld_valid && res_valid;

    assign insn_ready = run && !hazard && !mem_block && !alu_block;
    assign accept     = insn_valid && insn_ready;

    // store data (vs3) goes out through port a
    assign rd_idx_a = is_store ? vd : vs2;
    assign rd_idx_b = vs1;

    assign alu_valid   = accept && is_arith;
    assign alu_op      = op_dec;
    assign alu_use_imm = is_ivi;
    assign alu_imm     = vs1;
    assign alu_sew     = sew_q;
    assign alu_vd      = vd;
    assign alu_src_a   = rd_data_a;
    assign alu_src_b   = rd_data_b;

    assign mem_start = accept && is_mem;
    assign mem_we    = is_store;
    assign mem_addr  = rs1_value;
    assign mem_wdata = rd_data_a;
    assign mem_vd    = vd;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run   <= 1'b0;
            sew_q <= 2'd0;
            pend  <= '0;
        end else begin
            // intake opens one cycle after reset
            run <= 1'b1;
            // vsew lives in insn[25:23], top code is reserved
            if (accept && is_cfg) begin
                sew_q <= insn[24:23];
            end
            if (res_valid) begin
                pend[res_vd] <= 1'b0;
            end
            // load only writes when the alu leaves the port free
            if (ld_valid && !res_valid) begin
                pend[ld_vd] <= 1'b0;
            end
            if (accept && (is_arith || is_load)) begin
                pend[vd] <= 1'b1;
            end
        end
    end

endmodule

//--- hw/vec_pkg.sv
package vec_pkg;

    // register width in bits, one register per memory word
    localparam int VLEN       = 64;
    // architectural register count
    localparam int NUM_VEC    = 32;
    localparam int INSN_WIDTH = 32;
    // wishbone byte address width
    localparam int ADDR_WIDTH = 32;

    // one full vector register
    typedef logic [VLEN-1:0]       vreg_t;
    // register index from the 5-bit fields
    typedef logic [4:0]            vidx_t;
    typedef logic [INSN_WIDTH-1:0] insn_t;
    typedef logic [ADDR_WIDTH-1:0] waddr_t;

    // element width code
    // 0 is 8 bits, 1 is 16, 2 is 32, 3 is 64
    typedef logic [1:0] sew_t;

    // lane-wise operations the alu knows
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_t;

    // major opcodes
    localparam logic [6:0] OPC_LOAD  = 7'h07;
    localparam logic [6:0] OPC_STORE = 7'h27;
    localparam logic [6:0] OPC_OPV   = 7'h57;

    // minor opcodes in funct3
    localparam logic [2:0] F3_IVV = 3'd0;
    localparam logic [2:0] F3_IVI = 3'd3;
    // vsetvli and friends
    localparam logic [2:0] F3_CFG = 3'd7;

    // funct6 codes for the integer ops
    localparam logic [5:0] F6_ADD = 6'h00;
    localparam logic [5:0] F6_SUB = 6'h02;
    localparam logic [5:0] F6_AND = 6'h09;
    localparam logic [5:0] F6_OR  = 6'h0a;
    localparam logic [5:0] F6_XOR = 6'h0b;

endpackage
